//--- verilog/sh_bus_params.svh
`ifndef SH_BUS_PARAMS_SVH
`define SH_BUS_PARAMS_SVH

//**************************************************************************
// Bus geometry
//**************************************************************************
`define SH_ADDR_W 32
`define SH_DATA_W 32

// SH instructions are one halfword
`define SH_INSTR_W 16

// Lane 3 is the byte at offset 0
`define SH_LANES 4

//**************************************************************************
// Fetch start
//**************************************************************************
`define SH_RESET_PC 32'h0000_0000

`endif

//--- verilog/sh_bus_pkg.sv
`include "sh_bus_params.svh"

package sh_bus_pkg;

	// Byte address on the external bus
	typedef logic [`SH_ADDR_W-1:0] addr_t;

	// One bus data word
	typedef logic [`SH_DATA_W-1:0] word_t;

	// One instruction
	typedef logic [`SH_INSTR_W-1:0] instr_t;

	// Byte enables, big-endian order
	typedef logic [`SH_LANES-1:0] lanes_t;

	// Load/store size
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_WORD = 2'd1,
		SZ_LONG = 2'd2
	} acc_size_t;

endpackage

//--- verilog/sh_fetch_unit.sv
`timescale 1ns/1ps
`include "sh_bus_params.svh"

module sh_fetch_unit (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               br_req,
	input  sh_bus_pkg::addr_t  br_pc,
	input  logic               fetch_done,
	input  sh_bus_pkg::word_t  bus_di,
	output logic               fetch_req,
	output sh_bus_pkg::addr_t  fetch_addr,
	output sh_bus_pkg::instr_t ir,
	output sh_bus_pkg::addr_t  ir_pc,
	output logic               ir_valid
);

	sh_bus_pkg::addr_t  pc;
	sh_bus_pkg::addr_t  hold_addr;
	sh_bus_pkg::instr_t save_ir;
	sh_bus_pkg::instr_t bus_ir;
	logic               save_valid;
	logic               discard;
	logic               run;
	logic               take_bus;
	logic               take_save;

	//**************************************************************************
	// Word request
	//**************************************************************************
	// pc is the next instruction still to be delivered
	assign fetch_req = run & ~save_valid;

	// Overtaken fetch keeps its old address until the bus lets it go
	assign fetch_addr = discard ? hold_addr : {pc[`SH_ADDR_W-1:2], 2'b00};

	assign take_bus = fetch_done & ~discard & ~br_req;
	assign take_save = save_valid & ~br_req;

	// Even halfword sits in the upper half of the word
	assign bus_ir = pc[1] ? bus_di[`SH_INSTR_W-1:0] : bus_di[`SH_DATA_W-1:`SH_INSTR_W];

	//**************************************************************************
	// PC and delivery control
	//**************************************************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= `SH_RESET_PC;
			save_valid <= 1'b0;
			discard <= 1'b0;
			run <= 1'b0;
			ir_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			ir_valid <= take_bus | take_save;

			if (br_req) begin
				pc <= {br_pc[`SH_ADDR_W-1:1], 1'b0};
				save_valid <= 1'b0;
			end else if (take_bus) begin
				pc <= pc + sh_bus_pkg::addr_t'(2);
				// Lower half follows from the saved register
				save_valid <= ~pc[1];
			end else if (take_save) begin
				pc <= pc + sh_bus_pkg::addr_t'(2);
				save_valid <= 1'b0;
			end

			if (fetch_done) begin
				discard <= 1'b0;
			end else if (br_req && fetch_req) begin
				discard <= 1'b1;
			end
		end
	end

	//**************************************************************************
	// Instruction and saved halfword
	//**************************************************************************
	always_ff @(posedge CLK) begin
		if (!discard) begin
			hold_addr <= fetch_addr;
		end

		if (take_bus) begin
			ir <= bus_ir;
			ir_pc <= pc;
			save_ir <= bus_di[`SH_INSTR_W-1:0];
		end else if (take_save) begin
			ir <= save_ir;
			ir_pc <= pc;
		end
	end

endmodule

//--- verilog/sh_mem_access.sv
`timescale 1ns/1ps
`include "sh_bus_params.svh"

module sh_mem_access (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ma_req,
	input  sh_bus_pkg::addr_t     ma_addr,
	input  sh_bus_pkg::acc_size_t ma_size,
	input  logic                  ma_we,
	input  sh_bus_pkg::word_t     ma_wd,
	input  logic                  ma_done_bus,
	input  sh_bus_pkg::word_t     bus_di,
	output logic                  ma_busy,
	output logic                  ma_done,
	output sh_bus_pkg::word_t     ma_rdata,
	output logic                  ma_bus_req,
	output sh_bus_pkg::addr_t     ma_bus_addr,
	output logic                  ma_bus_we,
	output sh_bus_pkg::lanes_t    ma_bus_lanes,
	output sh_bus_pkg::word_t     ma_bus_wd
);

	sh_bus_pkg::addr_t     addr_q;
	sh_bus_pkg::acc_size_t size_q;
	sh_bus_pkg::word_t     wd_q;
	sh_bus_pkg::word_t     rd_shift;
	sh_bus_pkg::word_t     rd_ext;
	logic                  we_q;
	logic                  busy;
	logic [1:0]            lane_off;

	assign ma_busy = busy;
	assign ma_bus_req = busy;
	assign ma_bus_addr = addr_q;
	assign ma_bus_we = we_q;

	//**************************************************************************
	// Lanes and write replication
	//**************************************************************************
	// lane_off counts bytes up from the bottom of the word
	always_comb begin
		case (size_q)
			sh_bus_pkg::SZ_BYTE: begin
				ma_bus_lanes = sh_bus_pkg::lanes_t'(4'b1000) >> addr_q[1:0];
				ma_bus_wd = {(`SH_LANES){wd_q[7:0]}};
				lane_off = ~addr_q[1:0];
			end
			sh_bus_pkg::SZ_WORD: begin
				ma_bus_lanes = addr_q[1] ? sh_bus_pkg::lanes_t'(4'b0011)
				                         : sh_bus_pkg::lanes_t'(4'b1100);
				ma_bus_wd = {2{wd_q[15:0]}};
				lane_off = {~addr_q[1], 1'b0};
			end
			default: begin
				ma_bus_lanes = '1;
				ma_bus_wd = wd_q;
				lane_off = 2'b00;
			end
		endcase
	end

	//**************************************************************************
	// Read alignment
	//**************************************************************************
	assign rd_shift = bus_di >> {lane_off, 3'b000};

	always_comb begin
		case (size_q)
			sh_bus_pkg::SZ_BYTE: rd_ext = {{(`SH_DATA_W-8){rd_shift[7]}}, rd_shift[7:0]};
			sh_bus_pkg::SZ_WORD: rd_ext = {{(`SH_DATA_W-16){rd_shift[15]}}, rd_shift[15:0]};
			default:             rd_ext = rd_shift;
		endcase
	end

	//**************************************************************************
	// Request tracking
	//**************************************************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busy <= 1'b0;
			ma_done <= 1'b0;
		end else begin
			ma_done <= ma_done_bus;
			if (ma_done_bus) begin
				busy <= 1'b0;
			end else if (ma_req && !busy) begin
				busy <= 1'b1;
			end
		end
	end

	// Only one access in flight
	always_ff @(posedge CLK) begin
		if (ma_req && !busy) begin
			addr_q <= ma_addr;
			size_q <= ma_size;
			we_q <= ma_we;
			wd_q <= ma_wd;
		end

		if (ma_done_bus) begin
			ma_rdata <= rd_ext;
		end
	end

endmodule

//--- verilog/sh_bus_arbiter.sv
`timescale 1ns/1ps
`include "sh_bus_params.svh"

module sh_bus_arbiter (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               fetch_req,
	input  sh_bus_pkg::addr_t  fetch_addr,
	input  logic               ma_bus_req,
	input  sh_bus_pkg::addr_t  ma_bus_addr,
	input  logic               ma_bus_we,
	input  sh_bus_pkg::lanes_t ma_bus_lanes,
	input  sh_bus_pkg::word_t  ma_bus_wd,
	input  logic               bus_wait,
	output logic               fetch_done,
	output logic               ma_done_bus,
	output logic               bus_req,
	output sh_bus_pkg::addr_t  bus_a,
	output logic               bus_wr,
	output sh_bus_pkg::lanes_t bus_ba,
	output sh_bus_pkg::word_t  bus_do
);

	logic lock;
	logic owner_data;
	logic sel_data;

	// Stretched transfer keeps its owner, otherwise data goes first
	assign sel_data = lock ? owner_data : ma_bus_req;

	//**************************************************************************
	// Bus outputs
	//**************************************************************************
	assign bus_req = sel_data ? ma_bus_req : fetch_req;
	assign bus_a = sel_data ? ma_bus_addr : fetch_addr;
	assign bus_wr = sel_data & ma_bus_req & ma_bus_we;
	assign bus_ba = sel_data ? ma_bus_lanes : {(`SH_LANES){1'b1}};
	assign bus_do = ma_bus_wd;

	assign fetch_done = ~sel_data & fetch_req & ~bus_wait;
	assign ma_done_bus = sel_data & ma_bus_req & ~bus_wait;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lock <= 1'b0;
			owner_data <= 1'b0;
		end else begin
			lock <= bus_req & bus_wait;
			owner_data <= sel_data;
		end
	end

endmodule

//--- verilog/sh_bus_unit.sv
`timescale 1ns/1ps

module sh_bus_unit (
	input  logic                  CLK,
	input  logic                  RST_N,

	output sh_bus_pkg::addr_t     bus_a,
	input  sh_bus_pkg::word_t     bus_di,
	output sh_bus_pkg::word_t     bus_do,
	output logic                  bus_wr,
	output sh_bus_pkg::lanes_t    bus_ba,
	output logic                  bus_req,
	input  logic                  bus_wait,

	input  logic                  br_req,
	input  sh_bus_pkg::addr_t     br_pc,
	output sh_bus_pkg::instr_t    ir,
	output sh_bus_pkg::addr_t     ir_pc,
	output logic                  ir_valid,

	input  logic                  ma_req,
	input  sh_bus_pkg::addr_t     ma_addr,
	input  sh_bus_pkg::acc_size_t ma_size,
	input  logic                  ma_we,
	input  sh_bus_pkg::word_t     ma_wd,
	output logic                  ma_busy,
	output logic                  ma_done,
	output sh_bus_pkg::word_t     ma_rdata
);

	logic               fetch_req;
	logic               fetch_done;
	sh_bus_pkg::addr_t  fetch_addr;
	logic               ma_bus_req;
	logic               ma_done_bus;
	logic               ma_bus_we;
	sh_bus_pkg::addr_t  ma_bus_addr;
	sh_bus_pkg::lanes_t ma_bus_lanes;
	sh_bus_pkg::word_t  ma_bus_wd;

	sh_fetch_unit fetch (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.br_req     (br_req),
		.br_pc      (br_pc),
		.fetch_done (fetch_done),
		.bus_di     (bus_di),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.ir         (ir),
		.ir_pc      (ir_pc),
		.ir_valid   (ir_valid)
	);

	sh_mem_access mem (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.ma_req       (ma_req),
		.ma_addr      (ma_addr),
		.ma_size      (ma_size),
		.ma_we        (ma_we),
		.ma_wd        (ma_wd),
		.ma_done_bus  (ma_done_bus),
		.bus_di       (bus_di),
		.ma_busy      (ma_busy),
		.ma_done      (ma_done),
		.ma_rdata     (ma_rdata),
		.ma_bus_req   (ma_bus_req),
		.ma_bus_addr  (ma_bus_addr),
		.ma_bus_we    (ma_bus_we),
		.ma_bus_lanes (ma_bus_lanes),
		.ma_bus_wd    (ma_bus_wd)
	);

	sh_bus_arbiter arb (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.ma_bus_req   (ma_bus_req),
		.ma_bus_addr  (ma_bus_addr),
		.ma_bus_we    (ma_bus_we),
		.ma_bus_lanes (ma_bus_lanes),
		.ma_bus_wd    (ma_bus_wd),
		.bus_wait     (bus_wait),
		.fetch_done   (fetch_done),
		.ma_done_bus  (ma_done_bus),
		.bus_req      (bus_req),
		.bus_a        (bus_a),
		.bus_wr       (bus_wr),
		.bus_ba       (bus_ba),
		.bus_do       (bus_do)
	);

endmodule

//--- bench/tb_sh_bus_unit.sv
`timescale 1ns/1ps
`include "sh_bus_params.svh"

module tb_sh_bus_unit;

	localparam int NUM_OPS = 200;
	localparam int WARMUP = 60;
	localparam int MEM_WORDS = 512;
	localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;

	logic CLK, RST_N, bus_wr, bus_req, bus_wait, br_req, ir_valid;
	logic ma_req, ma_we, ma_busy, ma_done;
	sh_bus_pkg::addr_t bus_a, br_pc, ir_pc, ma_addr;
	sh_bus_pkg::word_t bus_di, bus_do, ma_wd, ma_rdata;
	sh_bus_pkg::lanes_t bus_ba;
	sh_bus_pkg::instr_t ir;
	sh_bus_pkg::acc_size_t ma_size;

	// Bus memory and the reference copy
	sh_bus_pkg::word_t bus_mem [MEM_WORDS];
	sh_bus_pkg::word_t ref_mem [MEM_WORDS];
	logic [15:0] lfsr;
	int instr_errs = 0;
	int word_errs = 0;
	int lane_errs = 0;
	int other_errs = 0;
	int cycles = 0;
	int cyc, i, waits_left, ops_issued, ops_done, instr_count;
	sh_bus_pkg::addr_t exp_pc, cur_addr, xfer_a;
	sh_bus_pkg::acc_size_t cur_size;
	sh_bus_pkg::word_t cur_wd, xfer_do, fill;
	sh_bus_pkg::lanes_t xfer_ba;
	logic op_pend, cur_we, xfer_pend, xfer_wr;

	sh_bus_unit UUT (.*);

	// Reads are combinational, valid in the completing cycle
	assign bus_di = bus_mem[bus_a[10:2]];

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	//**************************************************************************
	// Random numbers and reference rules
	//**************************************************************************
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic int nbytes(input sh_bus_pkg::acc_size_t size);
		case (size)
			sh_bus_pkg::SZ_BYTE: return 1;
			sh_bus_pkg::SZ_WORD: return 2;
			default: return 4;
		endcase
	endfunction

	// Lane 3 carries byte offset 0
	function automatic sh_bus_pkg::lanes_t lanes_for(input sh_bus_pkg::acc_size_t size,
			input sh_bus_pkg::addr_t a);
		sh_bus_pkg::lanes_t l;
		int k;
		for (k = 0; k < 4; k++) begin
			l[3-k] = (k >= int'(a[1:0])) && (k < int'(a[1:0]) + nbytes(size));
		end
		return l;
	endfunction

	function automatic sh_bus_pkg::word_t lane_mask(input sh_bus_pkg::lanes_t l);
		sh_bus_pkg::word_t m;
		int k;
		for (k = 0; k < 4; k++) begin
			m[8*k +: 8] = {8{l[k]}};
		end
		return m;
	endfunction

	// Most significant byte of the value goes to the lowest address
	function automatic sh_bus_pkg::word_t place_bytes(input sh_bus_pkg::word_t base,
			input sh_bus_pkg::acc_size_t size, input sh_bus_pkg::addr_t a,
			input sh_bus_pkg::word_t wd);
		sh_bus_pkg::word_t w;
		int n, k, off;
		w = base;
		n = nbytes(size);
		for (k = 0; k < n; k++) begin
			off = int'(a[1:0]) + k;
			w[8*(3-off) +: 8] = wd[8*(n-1-k) +: 8];
		end
		return w;
	endfunction

	function automatic sh_bus_pkg::word_t load_value(input sh_bus_pkg::acc_size_t size,
			input sh_bus_pkg::addr_t a);
		sh_bus_pkg::word_t w, v;
		int n, k, off;
		w = ref_mem[a[10:2]];
		n = nbytes(size);
		v = '0;
		for (k = 0; k < n; k++) begin
			off = int'(a[1:0]) + k;
			v = {v[23:0], w[8*(3-off) +: 8]};
		end
		if (v[8*n-1]) begin
			v = v | (32'hFFFF_FFFF << (8*n));
		end
		return v;
	endfunction

	function automatic sh_bus_pkg::instr_t ref_instr(input sh_bus_pkg::addr_t pc);
		sh_bus_pkg::word_t w;
		w = ref_mem[pc[10:2]];
		return pc[1] ? w[15:0] : w[31:16];
	endfunction

	//**************************************************************************
	// Compare tasks
	//**************************************************************************
	task automatic check_instr(input sh_bus_pkg::instr_t got_ir, input sh_bus_pkg::addr_t got_pc,
			input sh_bus_pkg::instr_t want_ir, input sh_bus_pkg::addr_t want_pc);
		if (got_pc !== want_pc) begin
			$display("Fail ir_pc: got %h, expected %h", got_pc, want_pc);
			instr_errs++;
		end else if (got_ir !== want_ir) begin
			$display("Fail ir: got %h, expected %h at ir_pc %h", got_ir, want_ir, got_pc);
			instr_errs++;
		end
	endtask

	task automatic check_word(input string name, input sh_bus_pkg::word_t got,
			input sh_bus_pkg::word_t want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			word_errs++;
		end
	endtask

	task automatic check_lanes(input string name, input sh_bus_pkg::lanes_t got,
			input sh_bus_pkg::lanes_t want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			lane_errs++;
		end
	endtask

	task automatic check_low(input string name, input logic v);
		if (v !== 1'b0) begin
			$display("Fail %s: got %h, expected 0", name, v);
			other_errs++;
		end
	endtask

	task automatic note_error(input string msg);
		$display("Error: %s", msg);
		other_errs++;
	endtask

	task automatic print_counts();
		$display("Errors: instr %0d, word %0d, lanes %0d, other %0d (%0d instr, %0d accesses)",
			instr_errs, word_errs, lane_errs, other_errs, instr_count, ops_done);
	endtask

	//**************************************************************************
	// Bus memory model
	//**************************************************************************
	task automatic check_transfer();
		int k;
		if (xfer_wr) begin
			for (k = 0; k < 4; k++) begin
				if (xfer_ba[k]) begin
					bus_mem[xfer_a[10:2]][8*k +: 8] = xfer_do[8*k +: 8];
				end
			end
		end
		// ma_done follows the data transfer by one cycle
		if (ma_done) begin
			check_word("bus_a", xfer_a, cur_addr);
			if (xfer_wr !== cur_we) begin
				$display("Fail bus_wr: got %h, expected %h", xfer_wr, cur_we);
				other_errs++;
			end
			check_lanes("bus_ba", xfer_ba, lanes_for(cur_size, cur_addr));
			if (cur_we) begin
				check_word("bus_do", xfer_do & lane_mask(lanes_for(cur_size, cur_addr)),
					place_bytes('0, cur_size, cur_addr, cur_wd));
			end
		end else begin
			if (xfer_wr) begin
				note_error("write transfer on the bus outside a data access");
			end
			check_lanes("bus_ba", xfer_ba, 4'hF);
		end
	endtask

	task automatic drive_wait();
		xfer_pend = 1'b0;
		if (bus_req && waits_left > 0) begin
			bus_wait = 1'b1;
			waits_left--;
		end else if (bus_req) begin
			bus_wait = 1'b0;
			xfer_pend = 1'b1;
			xfer_a = bus_a;
			xfer_wr = bus_wr;
			xfer_ba = bus_ba;
			xfer_do = bus_do;
			waits_left = int'(take_bits(2));
		end else begin
			bus_wait = 1'b0;
		end
	endtask

	task automatic issue_access();
		int sel;
		sel = int'(take_bits(2));
		cur_addr = 32'h0000_0400 | (take_bits(6) << 2);
		case (sel)
			0: begin
				cur_size = sh_bus_pkg::SZ_BYTE;
				cur_addr = cur_addr | take_bits(2);
			end
			1: begin
				cur_size = sh_bus_pkg::SZ_WORD;
				cur_addr = cur_addr | (take_bits(1) << 1);
			end
			default: cur_size = sh_bus_pkg::SZ_LONG;
		endcase
		cur_we = take_bits(1) != 32'd0;
		cur_wd = take_bits(32);
		ma_req = 1'b1;
		ma_addr = cur_addr;
		ma_size = cur_size;
		ma_we = cur_we;
		ma_wd = cur_wd;
		op_pend = 1'b1;
		ops_issued++;
	endtask

	//**************************************************************************
	// Stimulus and checking
	//**************************************************************************
	initial begin
		lfsr = 16'd4;
		RST_N = 1'b0;
		br_req = 1'b0;
		br_pc = '0;
		ma_req = 1'b0;
		ma_addr = '0;
		ma_size = sh_bus_pkg::SZ_BYTE;
		ma_we = 1'b0;
		ma_wd = '0;
		bus_wait = 1'b0;
		exp_pc = `SH_RESET_PC;
		op_pend = 1'b0;
		xfer_pend = 1'b0;
		waits_left = 0;
		cyc = 0;
		ops_issued = 0;
		ops_done = 0;
		instr_count = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			fill = take_bits(32);
			bus_mem[i] = fill;
			ref_mem[i] = fill;
		end

		repeat (10) @(posedge CLK);
		#1;
		check_low("bus_req", bus_req);
		check_low("bus_wr", bus_wr);
		check_low("ir_valid", ir_valid);
		check_low("ma_done", ma_done);
		check_low("ma_busy", ma_busy);
		RST_N = 1'b1;

		while (ops_done < NUM_OPS) begin
			@(posedge CLK);
			#1;
			cyc++;
			if (ma_done && !op_pend) begin
				note_error("ma_done pulsed with no access pending");
			end else if (ma_done && !xfer_pend) begin
				note_error("ma_done pulsed without a completed bus transfer");
			end
			if (xfer_pend) begin
				check_transfer();
			end
			// Accepted access keeps the unit busy until its done pulse
			if (op_pend && !ma_done && ma_busy !== 1'b1) begin
				$display("Fail ma_busy: got %h, expected 1", ma_busy);
				other_errs++;
			end
			if (ma_done && op_pend) begin
				check_low("ma_busy", ma_busy);
				if (cur_we) begin
					ref_mem[cur_addr[10:2]] = place_bytes(ref_mem[cur_addr[10:2]], cur_size,
						cur_addr, cur_wd);
				end else begin
					check_word("ma_rdata", ma_rdata, load_value(cur_size, cur_addr));
				end
				op_pend = 1'b0;
				ops_done++;
			end
			if (ir_valid) begin
				check_instr(ir, ir_pc, ref_instr(exp_pc), exp_pc);
				exp_pc = exp_pc + sh_bus_pkg::addr_t'(2);
				instr_count++;
			end

			drive_wait();

			br_req = 1'b0;
			ma_req = 1'b0;
			if (cyc > WARMUP) begin
				// Keep fetch below the data area
				if (exp_pc >= 32'h0000_0380 || take_bits(4) == 32'd0) begin
					br_req = 1'b1;
					br_pc = take_bits(9) & 32'h0000_01FE;
					exp_pc = br_pc;
				end
				if (!op_pend && ops_issued < NUM_OPS && take_bits(2) == 32'd0) begin
					issue_access();
				end
			end
		end

		if (instr_count < 50) begin
			note_error("too few instructions were delivered");
		end
		print_counts();
		if (instr_errs + word_errs + lane_errs + other_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_counts();
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+verilog
verilog/sh_bus_pkg.sv
verilog/sh_fetch_unit.sv
verilog/sh_mem_access.sv
verilog/sh_bus_arbiter.sv
verilog/sh_bus_unit.sv
bench/tb_sh_bus_unit.sv

//--- Makefile
# Verilator build and run of the bus unit testbench

VERILATOR ?= verilator
TOP       ?= tb_sh_bus_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
